// File: hdl/l2c_defs.svh
// all widths and the cache geometry are fixed at compile time and sets and ways must be powers of two
`ifndef L2C_DEFS_SVH
`define L2C_DEFS_SVH

// link side
`define L2C_ADDR_W 12
`define L2C_DATA_W 32
`define L2C_MASK_W 4
`define L2C_CORD_W 4
`define L2C_REG_ID_W 5

// cache geometry
`define L2C_SETS 8
`define L2C_WAYS 2
`define L2C_BLOCK_WORDS 4
`define L2C_CACHE_ADDR_W 13

// derived from the above
`define L2C_BYTE_OFF_W $clog2(`L2C_MASK_W)
`define L2C_BLOCK_OFF_W ($clog2(`L2C_BLOCK_WORDS) + `L2C_BYTE_OFF_W)
`define L2C_TAG_IDX_W ($clog2(`L2C_SETS) + $clog2(`L2C_WAYS))
`define L2C_TAG_CNT (`L2C_SETS * `L2C_WAYS)

`endif

// File: hdl/l2c_pkg.sv
// packet and opcode types of the bridge, with every width taken from the defs header
`default_nettype none

`include "l2c_defs.svh"

package l2c_pkg;

  typedef enum logic [1:0] {
    e_op_store,
    e_op_load,
    e_op_amo
  } req_op_e;

  typedef enum logic {
    e_amo_swap,
    e_amo_or
  } amo_e;

  typedef struct packed {
    logic float_wb;
    logic icache_fetch;
    logic is_byte_op;
    logic is_hex_op;
    logic is_unsigned_op;
    logic [`L2C_BYTE_OFF_W-1:0] part_sel;
  } load_info_s;

  typedef enum logic [3:0] {
    TAGST,
    TAGLA,
    SM,
    LW,
    LH,
    LHU,
    LB,
    LBU,
    AMOSWAP_W,
    AMOOR_W
  } cache_op_e;

  typedef enum logic [1:0] {
    e_ret_credit,
    e_ret_int_wb,
    e_ret_float_wb,
    e_ret_ifetch
  } ret_type_e;

  typedef struct packed {
    req_op_e op;
    amo_e amo;
    logic [`L2C_MASK_W-1:0] mask;
    logic [`L2C_ADDR_W-1:0] addr;
    logic [`L2C_DATA_W-1:0] payload;
    load_info_s load_info;
    logic [`L2C_REG_ID_W-1:0] reg_id;
    logic [`L2C_CORD_W-1:0] src_x;
    logic [`L2C_CORD_W-1:0] src_y;
  } req_pkt_s;

  // byte address, so two bits wider than the link word address minus its tag bit
  typedef struct packed {
    cache_op_e opcode;
    logic [`L2C_CACHE_ADDR_W-1:0] addr;
    logic [`L2C_DATA_W-1:0] data;
    logic [`L2C_MASK_W-1:0] mask;
  } cache_pkt_s;

  typedef struct packed {
    ret_type_e ret_type;
    logic [`L2C_DATA_W-1:0] data;
    logic [`L2C_REG_ID_W-1:0] reg_id;
    logic [`L2C_CORD_W-1:0] x;
    logic [`L2C_CORD_W-1:0] y;
  } ret_pkt_s;

endpackage

`default_nettype wire

// File: hdl/l2c_req_if.sv
// one valid/ready stream where valid and data must hold steady until ready is seen
`timescale 1ns/100ps
`default_nettype none

interface l2c_req_if #(
  parameter type payload_t = logic
) ();

  logic valid;
  logic ready;
  payload_t data;

  // producer side
  modport source (
    output valid,
    output data,
    input ready
  );

  // consumer side
  modport sink (
    input valid,
    input data,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/l2c_request_endpoint.sv
// one-entry input register with no skid slot, so req_ready_o follows the downstream ready
`timescale 1ns/100ps
`default_nettype none

`include "l2c_defs.svh"

module l2c_request_endpoint (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_v_i,
  input  l2c_pkg::req_op_e         req_op_i,
  input  l2c_pkg::amo_e            req_amo_i,
  input  logic [`L2C_MASK_W-1:0]   req_mask_i,
  input  logic [`L2C_ADDR_W-1:0]   req_addr_i,
  input  logic [`L2C_DATA_W-1:0]   req_data_i,
  input  l2c_pkg::load_info_s      req_load_info_i,
  input  logic [`L2C_REG_ID_W-1:0] req_reg_id_i,
  input  logic [`L2C_CORD_W-1:0]   req_src_x_i,
  input  logic [`L2C_CORD_W-1:0]   req_src_y_i,
  output logic                     req_ready_o,
  l2c_req_if.source                out_o
);

  logic valid_r;
  l2c_pkg::req_pkt_s pkt_r;
  logic accept;

  // room when empty or when the held request leaves this cycle
  assign req_ready_o = ~valid_r | out_o.ready;
  assign accept = req_v_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= 1'b0;
    end else if (accept) begin
      valid_r <= 1'b1;
    end else if (out_o.ready) begin
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_r <= '{
        op:        req_op_i,
        amo:       req_amo_i,
        mask:      req_mask_i,
        addr:      req_addr_i,
        payload:   req_data_i,
        load_info: req_load_info_i,
        reg_id:    req_reg_id_i,
        src_x:     req_src_x_i,
        src_y:     req_src_y_i
      };
    end
  end

  assign out_o.valid = valid_r;
  assign out_o.data = pkt_r;

endmodule

`default_nettype wire

// File: hdl/l2c_fifo.sv
// two-entry FIFO with no bypass, so data spends at least one cycle inside
`timescale 1ns/100ps
`default_nettype none

module l2c_fifo #(
  parameter type payload_t = logic
) (
  input logic       clk_i,
  input logic       reset_i,
  l2c_req_if.sink   in_i,
  l2c_req_if.source out_o
);

  payload_t mem [2];
  logic wr_ptr_r;
  logic rd_ptr_r;
  logic [1:0] count_r;
  logic push;
  logic pop;

  assign in_i.ready = (count_r != 2'd2);
  assign out_o.valid = (count_r != 2'd0);
  assign out_o.data = mem[rd_ptr_r];

  assign push = in_i.valid & in_i.ready;
  assign pop = out_o.valid & out_o.ready;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_r] <= in_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/l2c_cache_adapter.sv
// assumes an in-order two-stage cache that answers every packet once, stores included
`timescale 1ns/100ps
`default_nettype none

`include "l2c_defs.svh"

module l2c_cache_adapter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  l2c_req_if.sink                 req_i,
  output l2c_pkg::cache_pkt_s     cache_pkt_o,
  output logic                    cache_v_o,
  input  logic                    cache_ready_i,
  input  logic [`L2C_DATA_W-1:0]  cache_data_i,
  input  logic                    cache_v_i,
  output logic                    cache_yumi_o,
  input  logic                    cache_v_we_i,
  l2c_req_if.source               ret_o,
  output logic                    init_done_o
);

  localparam logic [`L2C_TAG_IDX_W:0] tag_cnt_lp = `L2C_TAG_CNT;
  localparam int tag_pad_lp = `L2C_CACHE_ADDR_W - `L2C_TAG_IDX_W - `L2C_BLOCK_OFF_W;

  typedef enum logic [1:0] {
    e_reset,
    e_clear_tag,
    e_ready
  } state_e;

  // what the return packet needs while the cache works on the request
  typedef struct packed {
    l2c_pkg::ret_type_e ret_type;
    logic [`L2C_REG_ID_W-1:0] reg_id;
    logic [`L2C_CORD_W-1:0] x;
    logic [`L2C_CORD_W-1:0] y;
  } tracker_s;

  state_e state_r;
  state_e state_n;
  logic [`L2C_TAG_IDX_W:0] sent_r;
  logic [`L2C_TAG_IDX_W:0] sent_n;
  logic [`L2C_TAG_IDX_W:0] recv_r;
  logic [`L2C_TAG_IDX_W:0] recv_n;
  logic clear_sent;
  logic clear_recv;

  l2c_pkg::req_pkt_s head;
  l2c_pkg::load_info_s load_info;
  l2c_pkg::cache_op_e data_op;
  l2c_pkg::ret_type_e ret_type;
  logic is_tag_space;
  logic [`L2C_BYTE_OFF_W-1:0] byte_off;
  tracker_s tl_info_r;
  tracker_s tv_info_r;

  assign head = req_i.data;
  assign load_info = head.load_info;
  // top address bit selects tag memory for debug access
  assign is_tag_space = head.addr[`L2C_ADDR_W-1];
  assign byte_off = (head.op == l2c_pkg::e_op_load) ? load_info.part_sel : '0;

  assign clear_sent = (sent_r == tag_cnt_lp);
  assign clear_recv = (recv_r == tag_cnt_lp);
  assign init_done_o = (state_r == e_ready);

  // data-space opcode
  always_comb begin
    if (head.op == l2c_pkg::e_op_store) begin
      data_op = l2c_pkg::SM;
    end else if (head.op == l2c_pkg::e_op_amo) begin
      if (head.amo == l2c_pkg::e_amo_or) begin
        data_op = l2c_pkg::AMOOR_W;
      end else begin
        data_op = l2c_pkg::AMOSWAP_W;
      end
    end else if (load_info.is_byte_op) begin
      if (load_info.is_unsigned_op) begin
        data_op = l2c_pkg::LBU;
      end else begin
        data_op = l2c_pkg::LB;
      end
    end else if (load_info.is_hex_op) begin
      if (load_info.is_unsigned_op) begin
        data_op = l2c_pkg::LHU;
      end else begin
        data_op = l2c_pkg::LH;
      end
    end else begin
      data_op = l2c_pkg::LW;
    end
  end

  always_comb begin
    if (head.op == l2c_pkg::e_op_store) begin
      ret_type = l2c_pkg::e_ret_credit;
    end else if (head.op == l2c_pkg::e_op_amo) begin
      ret_type = l2c_pkg::e_ret_int_wb;
    end else if (load_info.icache_fetch) begin
      ret_type = l2c_pkg::e_ret_ifetch;
    end else if (load_info.float_wb) begin
      ret_type = l2c_pkg::e_ret_float_wb;
    end else begin
      ret_type = l2c_pkg::e_ret_int_wb;
    end
  end

  always_comb begin
    state_n = state_r;
    sent_n = sent_r;
    recv_n = recv_r;
    cache_v_o = 1'b0;
    cache_yumi_o = 1'b0;
    req_i.ready = 1'b0;
    ret_o.valid = 1'b0;
    cache_pkt_o.opcode = l2c_pkg::TAGST;
    cache_pkt_o.addr = '0;
    cache_pkt_o.data = '0;
    cache_pkt_o.mask = '0;
    case (state_r)
      e_reset: begin
        state_n = e_clear_tag;
      end
      e_clear_tag: begin
        cache_v_o = ~clear_sent;
        // set/way index sits just above the block offset
        cache_pkt_o.addr = {
          {tag_pad_lp{1'b0}},
          sent_r[`L2C_TAG_IDX_W-1:0],
          {`L2C_BLOCK_OFF_W{1'b0}}
        };
        if (~clear_sent & cache_ready_i) begin
          sent_n = sent_r + 1'b1;
        end
        // tag clear answers are dropped here
        cache_yumi_o = cache_v_i;
        if (cache_v_i) begin
          recv_n = recv_r + 1'b1;
        end
        if (clear_sent & clear_recv) begin
          state_n = e_ready;
        end
      end
      e_ready: begin
        cache_v_o = req_i.valid;
        req_i.ready = cache_ready_i;
        if (!is_tag_space) begin
          cache_pkt_o.opcode = data_op;
        end else if (head.op == l2c_pkg::e_op_store) begin
          cache_pkt_o.opcode = l2c_pkg::TAGST;
        end else begin
          cache_pkt_o.opcode = l2c_pkg::TAGLA;
        end
        cache_pkt_o.addr = {head.addr[`L2C_ADDR_W-2:0], byte_off};
        cache_pkt_o.data = head.payload;
        cache_pkt_o.mask = head.mask;
        // hold the answer in the cache while the return FIFO is full
        ret_o.valid = cache_v_i;
        cache_yumi_o = cache_v_i & ret_o.ready;
      end
      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
      sent_r  <= '0;
      recv_r  <= '0;
    end else begin
      state_r <= state_n;
      sent_r  <= sent_n;
      recv_r  <= recv_n;
    end
  end

  // trackers follow the request through both cache stages
  always_ff @(posedge clk_i) begin
    if (req_i.valid & req_i.ready) begin
      tl_info_r <= '{ret_type: ret_type, reg_id: head.reg_id, x: head.src_x, y: head.src_y};
    end
    if (cache_v_we_i) begin
      tv_info_r <= tl_info_r;
    end
  end

  assign ret_o.data = '{
    ret_type: tv_info_r.ret_type,
    data:     cache_data_i,
    reg_id:   tv_info_r.reg_id,
    x:        tv_info_r.x,
    y:        tv_info_r.y
  };

endmodule

`default_nettype wire

// File: hdl/link_to_cache_top.sv
// requests are refused until the tag clear after reset has been fully acknowledged
`timescale 1ns/100ps
`default_nettype none

`include "l2c_defs.svh"

module link_to_cache_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_v_i,
  input  l2c_pkg::req_op_e         req_op_i,
  input  l2c_pkg::amo_e            req_amo_i,
  input  logic [`L2C_MASK_W-1:0]   req_mask_i,
  input  logic [`L2C_ADDR_W-1:0]   req_addr_i,
  input  logic [`L2C_DATA_W-1:0]   req_data_i,
  input  l2c_pkg::load_info_s      req_load_info_i,
  input  logic [`L2C_REG_ID_W-1:0] req_reg_id_i,
  input  logic [`L2C_CORD_W-1:0]   req_src_x_i,
  input  logic [`L2C_CORD_W-1:0]   req_src_y_i,
  output logic                     req_ready_o,
  output l2c_pkg::cache_pkt_s      cache_pkt_o,
  output logic                     cache_v_o,
  input  logic                     cache_ready_i,
  input  logic [`L2C_DATA_W-1:0]   cache_data_i,
  input  logic                     cache_v_i,
  output logic                     cache_yumi_o,
  input  logic                     cache_v_we_i,
  output logic                     ret_v_o,
  input  logic                     ret_ready_i,
  output l2c_pkg::ret_type_e       ret_type_o,
  output logic [`L2C_DATA_W-1:0]   ret_data_o,
  output logic [`L2C_REG_ID_W-1:0] ret_reg_id_o,
  output logic [`L2C_CORD_W-1:0]   ret_x_o,
  output logic [`L2C_CORD_W-1:0]   ret_y_o
);

  logic init_done;
  logic ep_v_li;
  logic ep_ready_lo;

  l2c_req_if #(.payload_t(l2c_pkg::req_pkt_s)) ep_req_if ();
  l2c_req_if #(.payload_t(l2c_pkg::req_pkt_s)) fifo_req_if ();
  l2c_req_if #(.payload_t(l2c_pkg::ret_pkt_s)) adapter_ret_if ();
  l2c_req_if #(.payload_t(l2c_pkg::ret_pkt_s)) fifo_ret_if ();

  // no network traffic before the tag clear ends
  assign ep_v_li = req_v_i & init_done;
  assign req_ready_o = ep_ready_lo & init_done;

  l2c_request_endpoint endpoint (
    .clk_i(clk_i), .reset_i(reset_i), .req_v_i(ep_v_li), .req_op_i(req_op_i),
    .req_amo_i(req_amo_i), .req_mask_i(req_mask_i), .req_addr_i(req_addr_i),
    .req_data_i(req_data_i), .req_load_info_i(req_load_info_i),
    .req_reg_id_i(req_reg_id_i), .req_src_x_i(req_src_x_i), .req_src_y_i(req_src_y_i),
    .req_ready_o(ep_ready_lo), .out_o(ep_req_if.source)
  );

  l2c_fifo #(.payload_t(l2c_pkg::req_pkt_s)) req_fifo (
    .clk_i(clk_i), .reset_i(reset_i), .in_i(ep_req_if.sink), .out_o(fifo_req_if.source)
  );

  l2c_cache_adapter adapter (
    .clk_i(clk_i), .reset_i(reset_i), .req_i(fifo_req_if.sink),
    .cache_pkt_o(cache_pkt_o), .cache_v_o(cache_v_o), .cache_ready_i(cache_ready_i),
    .cache_data_i(cache_data_i), .cache_v_i(cache_v_i), .cache_yumi_o(cache_yumi_o),
    .cache_v_we_i(cache_v_we_i), .ret_o(adapter_ret_if.source), .init_done_o(init_done)
  );

  l2c_fifo #(.payload_t(l2c_pkg::ret_pkt_s)) ret_fifo (
    .clk_i(clk_i), .reset_i(reset_i), .in_i(adapter_ret_if.sink), .out_o(fifo_ret_if.source)
  );

  assign fifo_ret_if.ready = ret_ready_i;
  assign ret_v_o = fifo_ret_if.valid;
  assign ret_type_o = fifo_ret_if.data.ret_type;
  assign ret_data_o = fifo_ret_if.data.data;
  assign ret_reg_id_o = fifo_ret_if.data.reg_id;
  assign ret_x_o = fifo_ret_if.data.x;
  assign ret_y_o = fifo_ret_if.data.y;

endmodule

`default_nettype wire

// File: tests/tb_cache_model.sv
// stands in for the cache; holds one packet per stage, so at most two are in flight at once
`timescale 1ns/100ps
`default_nettype none

`include "l2c_defs.svh"

module tb_cache_model (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   v_i,
  output logic                   ready_o,
  output logic [`L2C_DATA_W-1:0] data_o,
  output logic                   v_o,
  input  logic                   yumi_i,
  output logic                   v_we_o
);

  logic [`L2C_DATA_W-1:0] mem [2048];
  logic [`L2C_DATA_W-1:0] tags [`L2C_TAG_CNT];
  logic [`L2C_DATA_W-1:0] ans_q [$];
  logic [`L2C_DATA_W-1:0] s2_data;
  logic s1_full;
  logic s2_full;
  int delay;
  integer seed;

  initial begin
    seed = 32'ha56cca84;
    // fill depends on every address bit
    for (int i = 0; i < 2048; i++) begin
      mem[i] = (i * 32'h9e3779b1) ^ {i[10:0], 21'h0};
    end
    for (int i = 0; i < `L2C_TAG_CNT; i++) begin
      tags[i] = 32'hdead0000 | i;
    end
    ready_o = 1'b0;
    data_o = '0;
    v_o = 1'b0;
    v_we_o = 1'b0;
    s1_full = 1'b0;
    s2_full = 1'b0;
    delay = 0;
    s2_data = '0;
  end

  // answer for one packet, applied to memory in acceptance order
  function automatic logic [`L2C_DATA_W-1:0] serve(input l2c_pkg::cache_pkt_s p);
    logic [`L2C_DATA_W-1:0] old;
    logic [`L2C_DATA_W-1:0] sh;
    logic [`L2C_DATA_W-1:0] ans;
    logic [10:0] w;
    logic [`L2C_TAG_IDX_W-1:0] ti;
    w = p.addr[`L2C_CACHE_ADDR_W-1:2];
    ti = p.addr[`L2C_BLOCK_OFF_W +: `L2C_TAG_IDX_W];
    old = mem[w];
    sh = old >> (8 * p.addr[1:0]);
    ans = '0;
    case (p.opcode)
      l2c_pkg::TAGST: tags[ti] = p.data;
      l2c_pkg::TAGLA: ans = tags[ti];
      l2c_pkg::SM: begin
        for (int i = 0; i < 4; i++) begin
          if (p.mask[i]) begin
            mem[w][8*i +: 8] = p.data[8*i +: 8];
          end
        end
      end
      l2c_pkg::LW: ans = old;
      l2c_pkg::LB: ans = {{24{sh[7]}}, sh[7:0]};
      l2c_pkg::LBU: ans = {24'h0, sh[7:0]};
      l2c_pkg::LH: ans = {{16{sh[15]}}, sh[15:0]};
      l2c_pkg::LHU: ans = {16'h0, sh[15:0]};
      l2c_pkg::AMOSWAP_W: begin
        ans = old;
        mem[w] = p.data;
      end
      l2c_pkg::AMOOR_W: begin
        ans = old;
        mem[w] = old | p.data;
      end
      default: ans = 'x;
    endcase
    ans_q.push_back(ans);
    return ans;
  endfunction

  // stage moves decided at negedge, outputs driven after posedge
  always begin
    @(negedge clk_i);
    if (reset_i) begin
      s1_full = 1'b0;
      s2_full = 1'b0;
    end else begin
      if (v_o && yumi_i) begin
        s2_full = 1'b0;
      end
      if (v_we_o) begin
        s1_full = 1'b0;
        s2_full = 1'b1;
        s2_data = ans_q.pop_front();
        delay = $unsigned($random(seed)) % 3;
      end
      if (v_i && ready_o) begin
        s1_full = 1'b1;
      end
    end
    @(posedge clk_i);
    #2;
    if (s2_full && !v_o && delay > 0) begin
      delay--;
    end
    ready_o = !reset_i && !s1_full && (($random(seed) & 3) != 0);
    v_we_o = !reset_i && s1_full && !s2_full;
    v_o = !reset_i && s2_full && (delay == 0);
    data_o = s2_data;
  end

endmodule

`default_nettype wire

// File: tests/tb_link_to_cache.sv
// random traffic over a 16-word window and all tag sets; waits are bounded by cycle counts
`timescale 1ns/100ps
`default_nettype none

`include "l2c_defs.svh"

module tb_link_to_cache;

  logic clk_i = 1'b0;
  logic reset_i;
  logic req_v_i;
  logic req_ready_o;
  l2c_pkg::req_pkt_s req_drv;
  l2c_pkg::cache_pkt_s cache_pkt_o;
  logic cache_v_o, cache_ready_i, cache_v_i, cache_yumi_o, cache_v_we_i;
  logic [`L2C_DATA_W-1:0] cache_data_i;
  logic ret_v_o, ret_ready_i;
  l2c_pkg::ret_type_e ret_type_o;
  logic [`L2C_DATA_W-1:0] ret_data_o;
  logic [`L2C_REG_ID_W-1:0] ret_reg_id_o;
  logic [`L2C_CORD_W-1:0] ret_x_o, ret_y_o;

  l2c_pkg::req_pkt_s req_q [$];
  l2c_pkg::ret_pkt_s exp_ret_q [$];
  integer seed;
  int errors = 0;
  int tags_sent = 0;
  int clear_taken = 0;
  int rets_seen = 0;
  int sent = 0;
  logic timed_out = 1'b0;
  logic answer_taken = 1'b0;

  always #20 clk_i = ~clk_i;

  link_to_cache_top DUT (
    .clk_i(clk_i), .reset_i(reset_i), .req_v_i(req_v_i), .req_op_i(req_drv.op),
    .req_amo_i(req_drv.amo), .req_mask_i(req_drv.mask), .req_addr_i(req_drv.addr),
    .req_data_i(req_drv.payload), .req_load_info_i(req_drv.load_info),
    .req_reg_id_i(req_drv.reg_id), .req_src_x_i(req_drv.src_x), .req_src_y_i(req_drv.src_y),
    .req_ready_o(req_ready_o), .cache_pkt_o(cache_pkt_o), .cache_v_o(cache_v_o),
    .cache_ready_i(cache_ready_i), .cache_data_i(cache_data_i), .cache_v_i(cache_v_i),
    .cache_yumi_o(cache_yumi_o), .cache_v_we_i(cache_v_we_i), .ret_v_o(ret_v_o),
    .ret_ready_i(ret_ready_i), .ret_type_o(ret_type_o), .ret_data_o(ret_data_o),
    .ret_reg_id_o(ret_reg_id_o), .ret_x_o(ret_x_o), .ret_y_o(ret_y_o)
  );

  tb_cache_model model (
    .clk_i(clk_i), .reset_i(reset_i), .v_i(cache_v_o), .ready_o(cache_ready_i),
    .data_o(cache_data_i), .v_o(cache_v_i), .yumi_i(cache_yumi_o), .v_we_o(cache_v_we_i)
  );

  task automatic check_cache_pkt(input string name, input l2c_pkg::cache_pkt_s exp,
                                 input l2c_pkg::cache_pkt_s act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_ret_pkt(input string name, input l2c_pkg::ret_pkt_s exp,
                               input l2c_pkg::ret_pkt_s act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  function automatic l2c_pkg::cache_pkt_s expect_cache(input l2c_pkg::req_pkt_s r);
    l2c_pkg::cache_pkt_s p;
    logic [1:0] off;
    off = (r.op == l2c_pkg::e_op_load) ? r.load_info.part_sel : 2'b00;
    p.addr = {r.addr[`L2C_ADDR_W-2:0], off};
    p.data = r.payload;
    p.mask = r.mask;
    if (r.addr[`L2C_ADDR_W-1]) begin
      p.opcode = (r.op == l2c_pkg::e_op_store) ? l2c_pkg::TAGST : l2c_pkg::TAGLA;
    end else if (r.op == l2c_pkg::e_op_store) begin
      p.opcode = l2c_pkg::SM;
    end else if (r.op == l2c_pkg::e_op_amo) begin
      p.opcode = (r.amo == l2c_pkg::e_amo_or) ? l2c_pkg::AMOOR_W : l2c_pkg::AMOSWAP_W;
    end else if (r.load_info.is_byte_op) begin
      p.opcode = r.load_info.is_unsigned_op ? l2c_pkg::LBU : l2c_pkg::LB;
    end else if (r.load_info.is_hex_op) begin
      p.opcode = r.load_info.is_unsigned_op ? l2c_pkg::LHU : l2c_pkg::LH;
    end else begin
      p.opcode = l2c_pkg::LW;
    end
    return p;
  endfunction

  function automatic l2c_pkg::ret_type_e ret_type_of(input l2c_pkg::req_pkt_s r);
    if (r.op == l2c_pkg::e_op_store) return l2c_pkg::e_ret_credit;
    if (r.op == l2c_pkg::e_op_amo) return l2c_pkg::e_ret_int_wb;
    if (r.load_info.icache_fetch) return l2c_pkg::e_ret_ifetch;
    if (r.load_info.float_wb) return l2c_pkg::e_ret_float_wb;
    return l2c_pkg::e_ret_int_wb;
  endfunction

  function automatic l2c_pkg::req_pkt_s make_req(input int n);
    l2c_pkg::req_pkt_s r;
    int k;
    int lk;
    r = '0;
    k = $unsigned($random(seed)) % 10;
    r.op = (k < 3) ? l2c_pkg::e_op_store : (k < 5) ? l2c_pkg::e_op_amo : l2c_pkg::e_op_load;
    r.amo = l2c_pkg::amo_e'($random(seed) & 1);
    r.mask = $random(seed);
    r.payload = $random(seed);
    r.reg_id = n;
    r.src_x = $random(seed);
    r.src_y = $random(seed);
    lk = $unsigned($random(seed)) % 4;
    r.load_info.is_byte_op = (lk == 0);
    r.load_info.is_hex_op = (lk == 1);
    r.load_info.is_unsigned_op = $random(seed);
    r.load_info.float_wb = $random(seed);
    r.load_info.icache_fetch = (($random(seed) & 3) == 0);
    // halves stay aligned
    if (lk == 0) r.load_info.part_sel = $random(seed);
    if (lk == 1) r.load_info.part_sel = {1'($random(seed)), 1'b0};
    if ($unsigned($random(seed)) % 8 == 0) begin
      r.addr = {1'b1, 5'b0, 4'($random(seed)), 2'b0};
    end else begin
      r.addr = {1'b0, 7'b0, 4'($random(seed))};
    end
    return r;
  endfunction

  // everything sampled at negedge, where inputs and outputs are settled
  always @(negedge clk_i) begin
    l2c_pkg::req_pkt_s r;
    l2c_pkg::cache_pkt_s exp;
    logic [`L2C_DATA_W-1:0] ans;
    if (!reset_i) begin
      if (req_ready_o && clear_taken < `L2C_TAG_CNT) begin
        errors++;
        $display("req_ready_o went high at %0t before the tag clear finished", $time);
      end
      // an answer taken last cycle sits in the return FIFO by now
      if (answer_taken && !ret_v_o) begin
        errors++;
        $display("ret_v_o still low at %0t one cycle after an answer was taken", $time);
      end
      if (cache_yumi_o && !cache_v_i) begin
        errors++;
        $display("cache_yumi_o high at %0t with no answer from the cache", $time);
      end
      answer_taken = cache_v_i && cache_yumi_o && clear_taken == `L2C_TAG_CNT;
      if (req_v_i && req_ready_o) req_q.push_back(req_drv);
      if (cache_v_i && cache_yumi_o && clear_taken < `L2C_TAG_CNT) clear_taken++;
      if (cache_v_o && cache_ready_i) begin
        if (tags_sent < `L2C_TAG_CNT) begin
          exp = '0;
          exp.opcode = l2c_pkg::TAGST;
          exp.addr[`L2C_BLOCK_OFF_W +: `L2C_TAG_IDX_W] = tags_sent;
          check_cache_pkt("cache_pkt_o", exp, cache_pkt_o);
          ans = model.serve(exp);
          tags_sent++;
        end else if (req_q.size() == 0) begin
          errors++;
          $display("cache packet at %0t with no request pending", $time);
        end else begin
          r = req_q.pop_front();
          exp = expect_cache(r);
          check_cache_pkt("cache_pkt_o", exp, cache_pkt_o);
          ans = model.serve(exp);
          exp_ret_q.push_back('{ret_type_of(r), ans, r.reg_id, r.src_x, r.src_y});
        end
      end
      if (ret_v_o && ret_ready_i) begin
        rets_seen++;
        if (exp_ret_q.size() == 0) begin
          errors++;
          $display("unexpected return at %0t", $time);
        end else begin
          check_ret_pkt("ret_pkt", exp_ret_q.pop_front(),
                        '{ret_type_o, ret_data_o, ret_reg_id_o, ret_x_o, ret_y_o});
        end
      end
    end
  end

  always @(posedge clk_i) begin
    #2;
    ret_ready_i = !reset_i && (($random(seed) & 3) != 0);
  end

  task automatic send_req(input l2c_pkg::req_pkt_s p);
    int cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    req_drv = p;
    req_v_i = 1'b1;
    while (!done && !timed_out) begin
      @(negedge clk_i);
      done = req_ready_o;
      @(posedge clk_i);
      #2;
      cycles++;
      if (!done && cycles > 200) begin
        timed_out = 1'b1;
        errors++;
        $display("request %0d was never accepted", p.reg_id);
      end
    end
    req_v_i = 1'b0;
    sent++;
  endtask

  initial begin
    int cycles;
    seed = 32'ha56cca84;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_drv = '0;
    ret_ready_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    cycles = 0;
    while (clear_taken < `L2C_TAG_CNT && !timed_out) begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > 500) begin
        timed_out = 1'b1;
        errors++;
        $display("tag clear never finished");
      end
    end
    for (int n = 0; n < 300 && !timed_out; n++) begin
      send_req(make_req(n));
    end
    cycles = 0;
    while (!timed_out && (rets_seen < sent || exp_ret_q.size() != 0)) begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > 5000) begin
        timed_out = 1'b1;
        errors++;
        $display("returns missing, %0d of %0d seen", rets_seen, sent);
      end
    end
    $display("%0d errors over %0d requests and %0d returns", errors, sent, rets_seen);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: link_to_cache.f
+incdir+hdl
hdl/l2c_pkg.sv
hdl/l2c_req_if.sv
hdl/l2c_request_endpoint.sv
hdl/l2c_fifo.sv
hdl/l2c_cache_adapter.sv
hdl/link_to_cache_top.sv
tests/tb_cache_model.sv
tests/tb_link_to_cache.sv
